/* src/udp_echo_pkg.sv */
/*
 * Shared types and constants for the UDP echo core: protocol field widths,
 * filter state encoding, echo port, reply constants and payload FIFO size
 */
`default_nettype none

package udp_echo_pkg;

    // Protocol field widths
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    // Port filter FSM
    typedef enum logic [1:0] {
        // No datagram open
        HDR_WAIT,
        // Payload goes to the FIFO
        PAYLOAD_ECHO,
        // Payload is consumed and discarded
        PAYLOAD_DROP
    } filter_state_t;

    // Only datagrams to this port get an answer
    localparam udp_port_t ECHO_PORT = 16'd1234;

    // Reply constants applied by the downstream UDP stack
    // Checksum is sent as zero, DSCP and ECN as zero
    localparam ip_addr_t LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam byte_t    REPLY_TTL = 8'd64;

    // Payload FIFO geometry
    localparam int PAYLOAD_FIFO_AW    = 6;
    localparam int PAYLOAD_FIFO_DEPTH = 1 << PAYLOAD_FIFO_AW;

endpackage

`default_nettype wire

/* src/udp_payload_if.sv */
/*
 * Byte-wide payload stream with valid/ready handshake and source/sink modports
 */
`default_nettype none
`timescale 1ns/1ps

interface udp_payload_if;

    udp_echo_pkg::byte_t tdata;
    logic                tvalid;
    logic                tready;
    // Final byte of a datagram
    logic                tlast;
    // Error flag carried along with the byte
    logic                tuser;

    modport source (
        output tdata,
        output tvalid,
        output tlast,
        output tuser,
        input  tready
    );

    modport sink (
        input  tdata,
        input  tvalid,
        input  tlast,
        input  tuser,
        output tready
    );

endinterface

`default_nettype wire

/* src/udp_port_filter.sv */
/*
 * Echo port filter: header match, reply header build and per-datagram
 * forward/drain of the received payload
 */
`default_nettype none
`timescale 1ns/1ps

module udp_port_filter (
    input  logic                    clk,
    input  logic                    rst,

    // Received UDP header
    input  logic                    rx_hdr_valid,
    output logic                    rx_hdr_ready,
    input  udp_echo_pkg::ip_addr_t  rx_ip_source_ip,
    input  udp_echo_pkg::udp_port_t rx_source_port,
    input  udp_echo_pkg::udp_port_t rx_dest_port,
    input  udp_echo_pkg::udp_len_t  rx_length,

    // Received payload
    input  udp_echo_pkg::byte_t     rx_payload_tdata,
    input  logic                    rx_payload_tvalid,
    output logic                    rx_payload_tready,
    input  logic                    rx_payload_tlast,
    input  logic                    rx_payload_tuser,

    // Reply header
    output logic                    tx_hdr_valid,
    input  logic                    tx_hdr_ready,
    output udp_echo_pkg::ip_addr_t  tx_ip_dest_ip,
    output udp_echo_pkg::udp_port_t tx_source_port,
    output udp_echo_pkg::udp_port_t tx_dest_port,
    output udp_echo_pkg::udp_len_t  tx_length,

    // Payload towards the FIFO
    udp_payload_if.source           fifo_out
);
    import udp_echo_pkg::*;

    filter_state_t state;
    filter_state_t state_next;
    logic          port_match;
    logic          hdr_xfer;
    logic          beat_xfer;
    logic          last_xfer;

    assign port_match = (rx_dest_port == ECHO_PORT);

    // Header handshake is open only between datagrams
    // A foreign port is acked at once and never reaches the tx side
    assign tx_hdr_valid = (state == HDR_WAIT) && rx_hdr_valid && port_match;
    assign rx_hdr_ready = (state == HDR_WAIT) && (port_match ? tx_hdr_ready : 1'b1);
    assign hdr_xfer     = rx_hdr_valid && rx_hdr_ready;

    // Reply goes back where it came from
    assign tx_ip_dest_ip  = rx_ip_source_ip;
    assign tx_source_port = rx_dest_port;
    assign tx_dest_port   = rx_source_port;
    assign tx_length      = rx_length;

    // Payload only reaches the FIFO for an echoed datagram
    assign fifo_out.tdata  = rx_payload_tdata;
    assign fifo_out.tvalid = rx_payload_tvalid && (state == PAYLOAD_ECHO);
    assign fifo_out.tlast  = rx_payload_tlast;
    assign fifo_out.tuser  = rx_payload_tuser;

    // Drain runs at full rate, echo follows FIFO back-pressure
    assign rx_payload_tready = (state == PAYLOAD_DROP) ||
                               ((state == PAYLOAD_ECHO) && fifo_out.tready);

    assign beat_xfer = rx_payload_tvalid && rx_payload_tready;
    assign last_xfer = beat_xfer && rx_payload_tlast;

    always_comb begin
        state_next = state;
        case (state)
            HDR_WAIT: begin
                // Decision is latched once per datagram
                if (hdr_xfer) begin
                    state_next = port_match ? PAYLOAD_ECHO : PAYLOAD_DROP;
                end
            end
            PAYLOAD_ECHO, PAYLOAD_DROP: begin
                if (last_xfer) begin
                    state_next = HDR_WAIT;
                end
            end
            default: begin
                state_next = HDR_WAIT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= HDR_WAIT;
        end else begin
            state <= state_next;
        end
    end

    // No second reply header while a payload is still open
    a_hdr_only_between_datagrams: assert property (
        @(posedge clk) disable iff (rst)
        hdr_xfer |=> !tx_hdr_valid
    );

    // First beat of a dropped datagram never leaks into the FIFO
    a_no_fifo_write_on_drop: assert property (
        @(posedge clk) disable iff (rst)
        (hdr_xfer && !port_match) |=> !fifo_out.tvalid
    );

endmodule

`default_nettype wire

/* src/udp_payload_fifo.sv */
/*
 * Payload byte FIFO: circular buffer with wrap-bit pointers and a registered
 * head word that bypasses the memory when the buffer runs empty
 */
`default_nettype none
`timescale 1ns/1ps

module udp_payload_fifo (
    input  logic          clk,
    input  logic          rst,
    udp_payload_if.sink   wr,
    udp_payload_if.source rd
);
    import udp_echo_pkg::*;

    // Entry is {tuser, tlast, tdata}
    logic [$bits(byte_t)+1:0] mem [PAYLOAD_FIFO_DEPTH];
    logic [$bits(byte_t)+1:0] wr_word;
    logic [$bits(byte_t)+1:0] out_word;

    logic [PAYLOAD_FIFO_AW:0] wr_ptr;
    logic [PAYLOAD_FIFO_AW:0] rd_ptr;
    logic [PAYLOAD_FIFO_AW:0] wr_ptr_next;
    logic [PAYLOAD_FIFO_AW:0] rd_ptr_next;
    logic [PAYLOAD_FIFO_AW:0] fill_level;

    logic full;
    logic empty;
    logic wr_xfer;
    logic rd_xfer;
    logic out_valid;

    assign wr_word = {wr.tuser, wr.tlast, wr.tdata};

    // Same index with different wrap bits means full
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PAYLOAD_FIFO_AW-1:0] == rd_ptr[PAYLOAD_FIFO_AW-1:0]) &&
                   (wr_ptr[PAYLOAD_FIFO_AW] != rd_ptr[PAYLOAD_FIFO_AW]);

    // Entries held, wrap bit included
    assign fill_level = wr_ptr - rd_ptr;

    assign wr.tready = !full;
    assign wr_xfer   = wr.tvalid && !full;
    assign rd_xfer   = out_valid && rd.tready;

    assign wr_ptr_next = wr_ptr + {{PAYLOAD_FIFO_AW{1'b0}}, wr_xfer};
    assign rd_ptr_next = rd_ptr + {{PAYLOAD_FIFO_AW{1'b0}}, rd_xfer};

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            out_valid <= 1'b0;
        end else begin
            wr_ptr    <= wr_ptr_next;
            rd_ptr    <= rd_ptr_next;
            // Output valid tracks occupancy one edge later
            out_valid <= (wr_ptr_next != rd_ptr_next);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_xfer) begin
            mem[wr_ptr[PAYLOAD_FIFO_AW-1:0]] <= wr_word;
        end
    end

    // Head word for the next cycle
    // New byte goes straight to the output when it becomes the head
    always_ff @(posedge clk) begin
        if (wr_xfer && (wr_ptr == rd_ptr_next)) begin
            out_word <= wr_word;
        end else begin
            out_word <= mem[rd_ptr_next[PAYLOAD_FIFO_AW-1:0]];
        end
    end

    assign rd.tvalid = out_valid;
    assign rd.tdata  = out_word[$bits(byte_t)-1:0];
    assign rd.tlast  = out_word[$bits(byte_t)];
    assign rd.tuser  = out_word[$bits(byte_t)+1];

    // A write into a full buffer would push the level past the depth
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (rst)
        fill_level <= PAYLOAD_FIFO_DEPTH
    );

    // Registered valid must agree with the pointer state
    a_no_valid_when_empty: assert property (
        @(posedge clk) disable iff (rst)
        empty |-> !rd.tvalid
    );

endmodule

`default_nettype wire

/* src/led_first_byte.sv */
/*
 * LED display of the first byte of each outgoing reply payload
 */
`default_nettype none
`timescale 1ns/1ps

module led_first_byte (
    input  logic                clk,
    input  logic                rst,
    // Observed only, tready comes from the downstream stack
    udp_payload_if.sink         mon,
    output udp_echo_pkg::byte_t led
);

    logic in_frame;
    logic beat_xfer;

    assign beat_xfer = mon.tvalid && mon.tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
            led      <= '0;
        end else if (beat_xfer) begin
            // First beat of a datagram
            if (!in_frame) begin
                led <= mon.tdata;
            end
            // Single-byte datagrams never open a frame
            in_frame <= !mon.tlast;
        end
    end

    a_led_changes_on_xfer: assert property (
        @(posedge clk) disable iff (rst)
        !beat_xfer |=> $stable(led)
    );

endmodule

`default_nettype wire

/* src/udp_echo_core.sv */
/*
 * UDP echo core top level: port filter, payload FIFO and LED stage
 */
`default_nettype none
`timescale 1ns/1ps

module udp_echo_core (
    input  logic                    clk,
    input  logic                    rst,

    // Received UDP header
    input  logic                    rx_hdr_valid,
    output logic                    rx_hdr_ready,
    input  udp_echo_pkg::ip_addr_t  rx_ip_source_ip,
    input  udp_echo_pkg::udp_port_t rx_source_port,
    input  udp_echo_pkg::udp_port_t rx_dest_port,
    input  udp_echo_pkg::udp_len_t  rx_length,

    // Received payload
    input  udp_echo_pkg::byte_t     rx_payload_tdata,
    input  logic                    rx_payload_tvalid,
    output logic                    rx_payload_tready,
    input  logic                    rx_payload_tlast,
    input  logic                    rx_payload_tuser,

    // Reply header
    output logic                    tx_hdr_valid,
    input  logic                    tx_hdr_ready,
    output udp_echo_pkg::ip_addr_t  tx_ip_dest_ip,
    output udp_echo_pkg::udp_port_t tx_source_port,
    output udp_echo_pkg::udp_port_t tx_dest_port,
    output udp_echo_pkg::udp_len_t  tx_length,

    // Reply payload
    output udp_echo_pkg::byte_t     tx_payload_tdata,
    output logic                    tx_payload_tvalid,
    input  logic                    tx_payload_tready,
    output logic                    tx_payload_tlast,
    output logic                    tx_payload_tuser,

    output udp_echo_pkg::byte_t     led
);

    udp_payload_if rx_fifo_if ();
    udp_payload_if tx_payload_if ();

    udp_port_filter u_filter (
        .clk               (clk),
        .rst               (rst),
        .rx_hdr_valid      (rx_hdr_valid),
        .rx_hdr_ready      (rx_hdr_ready),
        .rx_ip_source_ip   (rx_ip_source_ip),
        .rx_source_port    (rx_source_port),
        .rx_dest_port      (rx_dest_port),
        .rx_length         (rx_length),
        .rx_payload_tdata  (rx_payload_tdata),
        .rx_payload_tvalid (rx_payload_tvalid),
        .rx_payload_tready (rx_payload_tready),
        .rx_payload_tlast  (rx_payload_tlast),
        .rx_payload_tuser  (rx_payload_tuser),
        .tx_hdr_valid      (tx_hdr_valid),
        .tx_hdr_ready      (tx_hdr_ready),
        .tx_ip_dest_ip     (tx_ip_dest_ip),
        .tx_source_port    (tx_source_port),
        .tx_dest_port      (tx_dest_port),
        .tx_length         (tx_length),
        .fifo_out          (rx_fifo_if)
    );

    udp_payload_fifo u_fifo (
        .clk (clk),
        .rst (rst),
        .wr  (rx_fifo_if),
        .rd  (tx_payload_if)
    );

    led_first_byte u_led (
        .clk (clk),
        .rst (rst),
        .mon (tx_payload_if),
        .led (led)
    );

    // Reply payload stream out to the stack
    assign tx_payload_tdata     = tx_payload_if.tdata;
    assign tx_payload_tvalid    = tx_payload_if.tvalid;
    assign tx_payload_tlast     = tx_payload_if.tlast;
    assign tx_payload_tuser     = tx_payload_if.tuser;
    assign tx_payload_if.tready = tx_payload_tready;

endmodule

`default_nettype wire

/* verification/udp_echo_tasks.svh */
/*
 * Testbench helpers: LCG, value compare, timeout abort, datagram driver,
 * reply monitor and reply checks
 */
`ifndef UDP_ECHO_TASKS_SVH
`define UDP_ECHO_TASKS_SVH

// 32-bit LCG, upper bits returned
function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 8;
endfunction

task automatic check_equal(input string test_name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
        $display("FAILED %s: expected %0h, actual %0h", test_name, expected, actual);
        $display("Verification failed");
        $fatal(1);
    end
endtask

task automatic abort_on_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("Verification failed");
    $fatal(1);
endtask

task automatic fill_random(output byte_t data[$], input int count);
    int i;
    data = {};
    for (i = 0; i < count; i++) begin
        data.push_back(byte_t'(lcg_next()));
    end
endtask

// Header first, then one payload byte per accepted beat
task automatic send_datagram(input string test_name, input ip_addr_t src_ip,
                             input udp_port_t src_port, input udp_port_t dst_port,
                             input byte_t data[$], input logic user);
    int i;
    int cycles;
    rx_hdr_valid    <= 1'b1;
    rx_ip_source_ip <= src_ip;
    rx_source_port  <= src_port;
    rx_dest_port    <= dst_port;
    rx_length       <= udp_len_t'(8 + data.size());
    cycles = 0;
    do begin
        @(posedge clk);
        cycles++;
        if (cycles > WAIT_LIMIT) abort_on_timeout({test_name, " header accept"});
    end while (!rx_hdr_ready);
    rx_hdr_valid <= 1'b0;
    for (i = 0; i < data.size(); i++) begin
        rx_payload_tdata  <= data[i];
        rx_payload_tvalid <= 1'b1;
        rx_payload_tlast  <= (i == data.size() - 1);
        rx_payload_tuser  <= user;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) abort_on_timeout({test_name, " payload accept"});
        end while (!rx_payload_tready);
    end
    rx_payload_tvalid <= 1'b0;
    rx_payload_tlast  <= 1'b0;
endtask

task automatic collect_replies();
    forever begin
        @(posedge clk);
        if (tx_hdr_valid && tx_hdr_ready) begin
            hdr_q.push_back({tx_ip_dest_ip, tx_source_port, tx_dest_port, tx_length});
        end
        if (tx_payload_tvalid && tx_payload_tready) begin
            beat_q.push_back({tx_payload_tuser, tx_payload_tlast, tx_payload_tdata});
        end
    end
endtask

// Reply goes back to the sender with ports swapped
task automatic expect_reply(input string test_name, input ip_addr_t src_ip,
                            input udp_port_t src_port, input udp_port_t dst_port,
                            input byte_t data[$], input logic user);
    logic [79:0] hdr;
    logic [9:0]  beat;
    int          i;
    int          cycles;
    cycles = 0;
    do begin
        @(negedge clk);
        cycles++;
        if (cycles > WAIT_LIMIT) abort_on_timeout({test_name, " reply"});
    end while (hdr_q.size() == 0 || beat_q.size() < data.size());
    hdr = hdr_q.pop_front();
    check_equal({test_name, " dest ip"}, src_ip, hdr[79:48]);
    check_equal({test_name, " source port"}, dst_port, hdr[47:32]);
    check_equal({test_name, " dest port"}, src_port, hdr[31:16]);
    check_equal({test_name, " length"}, 8 + data.size(), hdr[15:0]);
    for (i = 0; i < data.size(); i++) begin
        beat = beat_q.pop_front();
        check_equal($sformatf("%s byte %0d data", test_name, i), data[i], beat[7:0]);
        check_equal($sformatf("%s byte %0d tlast", test_name, i), i == data.size() - 1,
                    beat[8]);
        check_equal($sformatf("%s byte %0d tuser", test_name, i), user, beat[9]);
    end
    check_equal({test_name, " led"}, data[0], led);
    @(posedge clk);
endtask

task automatic expect_no_reply(input string test_name, input byte_t led_before);
    repeat (20) @(negedge clk);
    check_equal({test_name, " no header"}, 0, hdr_q.size());
    check_equal({test_name, " no payload"}, 0, beat_q.size());
    check_equal({test_name, " led kept"}, led_before, led);
    @(posedge clk);
endtask

`endif

/* verification/udp_echo_tb.sv */
/*
 * Testbench top for the UDP echo core: clock, reset, DUT, reply monitor
 * and the directed test sequence
 */
`default_nettype none
`timescale 1ns/1ps

module udp_echo_tb;
    import udp_echo_pkg::*;

    localparam int WAIT_LIMIT = 1000;

    logic      clk = 1'b0;
    logic      rst;
    logic      rx_hdr_valid, rx_hdr_ready, tx_hdr_valid, tx_hdr_ready;
    ip_addr_t  rx_ip_source_ip, tx_ip_dest_ip;
    udp_port_t rx_source_port, rx_dest_port, tx_source_port, tx_dest_port;
    udp_len_t  rx_length, tx_length;
    byte_t     rx_payload_tdata, tx_payload_tdata, led;
    logic      rx_payload_tvalid, rx_payload_tready, rx_payload_tlast, rx_payload_tuser;
    logic      tx_payload_tvalid, tx_payload_tready, tx_payload_tlast, tx_payload_tuser;

    // Header entry is {dest ip, source port, dest port, length}
    logic [79:0] hdr_q[$];
    // Beat entry is {tuser, tlast, tdata}
    logic [9:0]  beat_q[$];
    int unsigned lcg_state = 15229;

    always #20 clk = ~clk;

    udp_echo_core u_udp_echo_core (.*);

    `include "udp_echo_tasks.svh"

    task automatic test_reset_state();
        @(negedge clk);
        check_equal("reset led", 0, led);
        check_equal("reset tx_payload_tvalid", 0, tx_payload_tvalid);
        check_equal("reset rx_payload_tready", 0, rx_payload_tready);
        @(posedge clk);
    endtask

    task automatic test_echo();
        byte_t data[$];
        fill_random(data, 12);
        send_datagram("echo", 32'hC0A8_0107, 16'd5000, ECHO_PORT, data, 1'b1);
        expect_reply("echo", 32'hC0A8_0107, 16'd5000, ECHO_PORT, data, 1'b1);
    endtask

    task automatic test_drop();
        byte_t data[$];
        byte_t led_before;
        led_before = led;
        fill_random(data, 16);
        send_datagram("drop", 32'hC0A8_0109, 16'd5001, 16'd4321, data, 1'b0);
        expect_no_reply("drop", led_before);
        // Filter must be back in shape for the next datagram
        fill_random(data, 8);
        send_datagram("after drop", 32'hC0A8_010A, 16'd5002, ECHO_PORT, data, 1'b0);
        expect_reply("after drop", 32'hC0A8_010A, 16'd5002, ECHO_PORT, data, 1'b0);
    endtask

    // Reply header waits unchanged, then the payload fills the FIFO
    task automatic hold_then_release(input ip_addr_t src_ip, input udp_port_t src_port,
                                     input udp_len_t length);
        repeat (10) begin
            @(negedge clk);
            check_equal("bp tx_hdr_valid", 1, tx_hdr_valid);
            check_equal("bp tx_ip_dest_ip", src_ip, tx_ip_dest_ip);
            check_equal("bp tx_source_port", ECHO_PORT, tx_source_port);
            check_equal("bp tx_dest_port", src_port, tx_dest_port);
            check_equal("bp tx_length", length, tx_length);
        end
        @(posedge clk);
        tx_hdr_ready <= 1'b1;
        repeat (60) @(negedge clk);
        check_equal("bp header taken", 1, hdr_q.size());
        check_equal("bp payload held", 0, beat_q.size());
        check_equal("bp tx_payload_tvalid", 1, tx_payload_tvalid);
        @(posedge clk);
        tx_payload_tready <= 1'b1;
    endtask

    task automatic test_back_pressure();
        byte_t data[$];
        fill_random(data, 40);
        tx_hdr_ready      <= 1'b0;
        tx_payload_tready <= 1'b0;
        fork
            send_datagram("bp", 32'hC0A8_0110, 16'd6000, ECHO_PORT, data, 1'b0);
            hold_then_release(32'hC0A8_0110, 16'd6000, 16'd48);
        join
        expect_reply("bp", 32'hC0A8_0110, 16'd6000, ECHO_PORT, data, 1'b0);
    endtask

    task automatic test_mixed_run();
        byte_t     data[$];
        byte_t     led_before;
        ip_addr_t  src_ip;
        udp_port_t src_port;
        udp_port_t port;
        logic      user;
        int        k;
        for (k = 0; k < 20; k++) begin
            fill_random(data, 1 + lcg_next() % 30);
            user = ((lcg_next() % 2) == 1);
            // Ports 2000 to 2999 never hit the echo port
            port = ((lcg_next() % 2) == 0) ? ECHO_PORT : udp_port_t'(2000 + lcg_next() % 1000);
            src_ip     = ip_addr_t'(32'hC0A8_0120 + k);
            src_port   = udp_port_t'(7000 + k);
            led_before = led;
            send_datagram($sformatf("mixed %0d", k), src_ip, src_port, port, data, user);
            if (port == ECHO_PORT) begin
                expect_reply($sformatf("mixed %0d", k), src_ip, src_port, port, data, user);
            end else begin
                expect_no_reply($sformatf("mixed %0d", k), led_before);
            end
        end
        check_equal("mixed leftover headers", 0, hdr_q.size());
        check_equal("mixed leftover beats", 0, beat_q.size());
    endtask

    initial begin
        rst               <= 1'b1;
        rx_hdr_valid      <= 1'b0;
        rx_ip_source_ip   <= '0;
        rx_source_port    <= '0;
        rx_dest_port      <= '0;
        rx_length         <= '0;
        rx_payload_tdata  <= '0;
        rx_payload_tvalid <= 1'b0;
        rx_payload_tlast  <= 1'b0;
        rx_payload_tuser  <= 1'b0;
        tx_hdr_ready      <= 1'b1;
        tx_payload_tready <= 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        fork
            collect_replies();
        join_none
        test_reset_state();
        test_echo();
        test_drop();
        test_back_pressure();
        test_mixed_run();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+verification
src/udp_echo_pkg.sv
src/udp_payload_if.sv
src/udp_port_filter.sv
src/udp_payload_fifo.sv
src/led_first_byte.sv
src/udp_echo_core.sv
verification/udp_echo_tb.sv
